/* Makefile */
.PHONY: run clean

run: obj_dir/Vtb_na_ct
	@out=$$(./obj_dir/Vtb_na_ct); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

obj_dir/Vtb_na_ct: tb.f $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
	verilator --binary --assert -f tb.f --top-module tb_na_ct -Mdir obj_dir

clean:
	rm -rf obj_dir

/* rtl/na_bus_decode.sv */
// AHB-Lite slave decoder: address phase capture, region select, response merge
`timescale 1ns/1ps
`include "na_macros.svh"

module na_bus_decode (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  na_pkg::bus_req_t bus_req_i,
  input  na_pkg::word_t    hwdata_i,
  output na_pkg::bus_rsp_t bus_rsp_o,
  input  na_pkg::bus_rsp_t conf_rsp_i,
  input  na_pkg::bus_rsp_t mp_rsp_i,
  output logic             dphase_conf_o,
  output logic             dphase_mp_o,
  output logic             dphase_write_o,
  output logic [3:0]       dphase_ofs_o,
  output logic             dphase_ch_o,
  output na_pkg::word_t    wdata_o
);

  na_pkg::region_e region_d;
  na_pkg::region_e region_q;
  logic [3:0]      region_bits;
  logic            addr_valid;
  logic            dph_valid_q;
  logic            write_q;
  logic [3:0]      ofs_q;
  logic            ch_q;

  ////////////////////
  // Address phase
  ////////////////////

  assign region_bits = bus_req_i.addr[`NA_ADDR_W-1 -: 4];
  assign addr_valid  = bus_req_i.sel && (bus_req_i.trans == `NA_HTRANS_NONSEQ);

  always_comb begin
    case (region_bits)
      `NA_REGION_CONF: region_d = na_pkg::REGION_CONF;
      `NA_REGION_MP:   region_d = na_pkg::REGION_MP;
      default:         region_d = na_pkg::REGION_NONE;
    endcase
  end

  // Held across wait states until the slave is ready
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dph_valid_q <= 1'b0;
      region_q    <= na_pkg::REGION_NONE;
      write_q     <= 1'b0;
      ofs_q       <= '0;
      ch_q        <= 1'b0;
    end else if (bus_rsp_o.ready) begin
      dph_valid_q <= addr_valid;
      region_q    <= region_d;
      write_q     <= bus_req_i.write;
      ofs_q       <= bus_req_i.addr[3:0];
      ch_q        <= bus_req_i.addr[`NA_CH_SEL_BIT];
    end
  end

  ////////////////////
  // Data phase
  ////////////////////

  assign dphase_conf_o  = dph_valid_q && (region_q == na_pkg::REGION_CONF);
  assign dphase_mp_o    = dph_valid_q && (region_q == na_pkg::REGION_MP);
  assign dphase_write_o = write_q;
  assign dphase_ofs_o   = ofs_q;
  assign dphase_ch_o    = ch_q;
  assign wdata_o        = hwdata_i;

  // Unmapped or idle: zero data, no wait
  always_comb begin
    bus_rsp_o.rdata = '0;
    bus_rsp_o.ready = 1'b1;
    if (dph_valid_q) begin
      case (region_q)
        na_pkg::REGION_CONF: bus_rsp_o = conf_rsp_i;
        na_pkg::REGION_MP:   bus_rsp_o = mp_rsp_i;
        default: ;
      endcase
    end
  end

endmodule

/* rtl/na_config.sv */
// Read-only tile identification registers
`timescale 1ns/1ps
`include "na_macros.svh"

module na_config (
  input  logic             dphase_i,
  input  logic [3:0]       ofs_i,
  output na_pkg::bus_rsp_t rsp_o
);

  na_pkg::word_t rdata;

  // Identification map
  always_comb begin
    case (ofs_i)
      4'h0:    rdata = `NA_TILE_ID;
      4'h4:    rdata = `NA_CORE_BASE;
      4'h8:    rdata = na_pkg::word_t'(`NA_CHANNELS);
      default: rdata = '0;
    endcase
  end

  // Writes land here without effect
  assign rsp_o.rdata = dphase_i ? rdata : '0;
  assign rsp_o.ready = 1'b1;

endmodule

/* rtl/na_ct.sv */
// Compute-tile network adapter top level
// Flit buffers, bus decoder, configuration block and message-passing endpoint
`timescale 1ns/1ps
`include "na_macros.svh"

module na_ct (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  na_pkg::flit_t [`NA_CHANNELS-1:0] noc_in_flit_i,
  input  na_pkg::chan_t                    noc_in_valid_i,
  output na_pkg::chan_t                    noc_in_ready_o,
  output na_pkg::flit_t [`NA_CHANNELS-1:0] noc_out_flit_o,
  output na_pkg::chan_t                    noc_out_valid_o,
  input  na_pkg::chan_t                    noc_out_ready_i,
  input  na_pkg::bus_req_t                 bus_req_i,
  input  na_pkg::word_t                    hwdata_i,
  output na_pkg::bus_rsp_t                 bus_rsp_o,
  output na_pkg::chan_t                    irq_o
);

  na_pkg::flit_t [`NA_CHANNELS-1:0] rx_flit;
  na_pkg::chan_t                    rx_valid;
  na_pkg::chan_t                    rx_ready;
  na_pkg::flit_t [`NA_CHANNELS-1:0] tx_flit;
  na_pkg::chan_t                    tx_valid;
  na_pkg::chan_t                    tx_ready;

  na_pkg::bus_rsp_t conf_rsp;
  na_pkg::bus_rsp_t mp_rsp;
  logic             dphase_conf;
  logic             dphase_mp;
  logic             dphase_write;
  logic [3:0]       dphase_ofs;
  logic             dphase_ch;
  na_pkg::word_t    wdata;

  ////////////////////
  // Flit buffers
  ////////////////////

  na_flit_buffer u_inbuffer0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_flit_i  (noc_in_flit_i[0]),
    .in_valid_i (noc_in_valid_i[0]),
    .in_ready_o (noc_in_ready_o[0]),
    .out_flit_o (rx_flit[0]),
    .out_valid_o(rx_valid[0]),
    .out_ready_i(rx_ready[0])
  );

  na_flit_buffer u_inbuffer1 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_flit_i  (noc_in_flit_i[1]),
    .in_valid_i (noc_in_valid_i[1]),
    .in_ready_o (noc_in_ready_o[1]),
    .out_flit_o (rx_flit[1]),
    .out_valid_o(rx_valid[1]),
    .out_ready_i(rx_ready[1])
  );

  na_flit_buffer u_outbuffer0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_flit_i  (tx_flit[0]),
    .in_valid_i (tx_valid[0]),
    .in_ready_o (tx_ready[0]),
    .out_flit_o (noc_out_flit_o[0]),
    .out_valid_o(noc_out_valid_o[0]),
    .out_ready_i(noc_out_ready_i[0])
  );

  na_flit_buffer u_outbuffer1 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_flit_i  (tx_flit[1]),
    .in_valid_i (tx_valid[1]),
    .in_ready_o (tx_ready[1]),
    .out_flit_o (noc_out_flit_o[1]),
    .out_valid_o(noc_out_valid_o[1]),
    .out_ready_i(noc_out_ready_i[1])
  );

  ////////////////////
  // Bus slave
  ////////////////////

  na_bus_decode u_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .bus_req_i     (bus_req_i),
    .hwdata_i      (hwdata_i),
    .bus_rsp_o     (bus_rsp_o),
    .conf_rsp_i    (conf_rsp),
    .mp_rsp_i      (mp_rsp),
    .dphase_conf_o (dphase_conf),
    .dphase_mp_o   (dphase_mp),
    .dphase_write_o(dphase_write),
    .dphase_ofs_o  (dphase_ofs),
    .dphase_ch_o   (dphase_ch),
    .wdata_o       (wdata)
  );

  na_config u_conf (
    .dphase_i(dphase_conf),
    .ofs_i   (dphase_ofs),
    .rsp_o   (conf_rsp)
  );

  na_mp_endpoint u_mp (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .dphase_i  (dphase_mp),
    .write_i   (dphase_write),
    .ofs_i     (dphase_ofs),
    .ch_i      (dphase_ch),
    .wdata_i   (wdata),
    .rsp_o     (mp_rsp),
    .rx_flit_i (rx_flit),
    .rx_valid_i(rx_valid),
    .rx_ready_o(rx_ready),
    .tx_flit_o (tx_flit),
    .tx_valid_o(tx_valid),
    .tx_ready_i(tx_ready),
    .irq_o     (irq_o)
  );

endmodule

/* rtl/na_flit_buffer.sv */
// Valid/ready flit FIFO with a registered head flit
`timescale 1ns/1ps
`include "na_macros.svh"

module na_flit_buffer #(
  parameter int DEPTH = `NA_BUF_DEPTH
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  na_pkg::flit_t in_flit_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  output na_pkg::flit_t out_flit_o,
  output logic          out_valid_o,
  input  logic          out_ready_i
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  na_pkg::flit_t    mem [DEPTH];
  na_pkg::flit_t    head_q;
  logic             head_valid_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] mem_cnt_q;
  logic [CNT_W-1:0] total;
  logic             en_q;
  logic             push;
  logic             pop;
  logic             load;

  // Stored flits include the head register
  assign total = mem_cnt_q + CNT_W'(head_valid_q);
  assign pop   = head_valid_q && out_ready_i;

  // Full buffer still takes a flit when the head leaves
  assign in_ready_o = en_q && ((total < CNT_W'(DEPTH)) || pop);
  assign push       = in_valid_i && in_ready_o;

  // Refill head when empty or leaving
  assign load = (mem_cnt_q != '0) && (!head_valid_q || out_ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q         <= 1'b0;
      head_valid_q <= 1'b0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      mem_cnt_q    <= '0;
    end else begin
      en_q <= 1'b1;
      if (push)
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (load) begin
        rd_ptr_q     <= rd_ptr_q + PTR_W'(1);
        head_valid_q <= 1'b1;
      end else if (pop) begin
        head_valid_q <= 1'b0;
      end
      mem_cnt_q <= mem_cnt_q + CNT_W'(push) - CNT_W'(load);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem[wr_ptr_q] <= in_flit_i;
    if (load)
      head_q <= mem[rd_ptr_q];
  end

  assign out_flit_o  = head_q;
  assign out_valid_o = head_valid_q;

endmodule

/* rtl/na_macros.svh */
// Widths, buffer depth, address map and tile identification constants
`ifndef NA_MACROS_SVH
`define NA_MACROS_SVH

// Bus word and flit payload width
`define NA_XLEN 32
`define NA_ADDR_W 24

// Channel 0 carries requests, channel 1 responses
`define NA_CHANNELS 2
`define NA_BUF_DEPTH 4

// Region codes in address bits 23..20
`define NA_REGION_CONF 4'h0
`define NA_REGION_MP 4'h1

`define NA_TILE_ID 32'h0000_0005
`define NA_CORE_BASE 32'h0000_0010

// Register byte offsets inside a region
`define NA_OFS_DATA 4'h0
`define NA_OFS_DATA_LAST 4'h4
`define NA_OFS_STATUS 4'h8
`define NA_CH_SEL_BIT 12

`define NA_HTRANS_NONSEQ 2'b10

`endif

/* rtl/na_mp_endpoint.sv */
// Message-passing endpoint: DATA, DATA_LAST and STATUS registers per channel
// Moves flits between the bus and the NoC buffers, raises per-channel interrupts
`timescale 1ns/1ps
`include "na_macros.svh"

module na_mp_endpoint (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 dphase_i,
  input  logic                                 write_i,
  input  logic [3:0]                           ofs_i,
  input  logic                                 ch_i,
  input  na_pkg::word_t                        wdata_i,
  output na_pkg::bus_rsp_t                     rsp_o,
  input  na_pkg::flit_t [`NA_CHANNELS-1:0]     rx_flit_i,
  input  na_pkg::chan_t                        rx_valid_i,
  output na_pkg::chan_t                        rx_ready_o,
  output na_pkg::flit_t [`NA_CHANNELS-1:0]     tx_flit_o,
  output na_pkg::chan_t                        tx_valid_o,
  input  na_pkg::chan_t                        tx_ready_i,
  output na_pkg::chan_t                        irq_o
);

  logic          wr_data;
  logic          rd_data;
  logic          rd_status;
  na_pkg::chan_t ch_sel;
  na_pkg::flit_t tx_flit;
  na_pkg::flit_t head;
  logic          head_valid;

  ////////////////////
  // Register decode
  ////////////////////

  assign wr_data = dphase_i && write_i &&
                   ((ofs_i == `NA_OFS_DATA) || (ofs_i == `NA_OFS_DATA_LAST));
  assign rd_data   = dphase_i && !write_i && (ofs_i == `NA_OFS_DATA);
  assign rd_status = dphase_i && !write_i && (ofs_i == `NA_OFS_STATUS);

  // One-hot channel from the address bit
  assign ch_sel = na_pkg::chan_t'(1) << ch_i;

  // Head flit of the addressed input buffer
  assign head       = rx_flit_i[ch_i];
  assign head_valid = rx_valid_i[ch_i];

  ////////////////////
  // Flit movement
  ////////////////////

  // DATA_LAST closes the packet
  assign tx_flit.last = (ofs_i == `NA_OFS_DATA_LAST);
  assign tx_flit.data = wdata_i;

  // Push and pop only towards the addressed channel
  always_comb begin
    for (int c = 0; c < `NA_CHANNELS; c++) begin
      tx_flit_o[c]  = tx_flit;
      tx_valid_o[c] = wr_data && ch_sel[c];
      rx_ready_o[c] = rd_data && ch_sel[c] && rx_valid_i[c];
    end
  end

  ////////////////////
  // Bus response
  ////////////////////

  always_comb begin
    // Write stalls while the output buffer is full
    rsp_o.ready = !(wr_data && !tx_ready_i[ch_i]);
    rsp_o.rdata = '0;
    if (rd_data && head_valid) begin
      rsp_o.rdata = head.data;
    end else if (rd_status) begin
      rsp_o.rdata = {{(`NA_XLEN-2){1'b0}}, head_valid && head.last, head_valid};
    end
  end

  // Pending flit interrupt, one per channel
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= rx_valid_i;
    end
  end

endmodule

/* rtl/na_pkg.sv */
// Flit and bus structs plus the width typedefs of the network adapter
`include "na_macros.svh"

package na_pkg;

  ////////////////////
  // Plain vectors
  ////////////////////

  typedef logic [`NA_XLEN-1:0] word_t;
  typedef logic [`NA_ADDR_W-1:0] addr_t;
  typedef logic [`NA_CHANNELS-1:0] chan_t;

  ////////////////////
  // Structs
  ////////////////////

  // One NoC flit, last marks the packet tail
  typedef struct packed {
    logic  last;
    word_t data;
  } flit_t;

  // AHB-Lite address phase
  typedef struct packed {
    logic       sel;
    logic       write;
    logic [1:0] trans;
    addr_t      addr;
  } bus_req_t;

  // Data phase response, hresp is always OKAY
  typedef struct packed {
    word_t rdata;
    logic  ready;
  } bus_rsp_t;

  // Slave regions behind the decoder
  typedef enum logic [1:0] {
    REGION_CONF,
    REGION_MP,
    REGION_NONE
  } region_e;

endpackage

/* tb.f */
+incdir+rtl
rtl/na_pkg.sv
rtl/na_flit_buffer.sv
rtl/na_bus_decode.sv
rtl/na_config.sv
rtl/na_mp_endpoint.sv
rtl/na_ct.sv
tb/na_ct_sva.sv
tb/tb_na_ct.sv

/* tb/na_ct_sva.sv */
// Assertions on the NoC output handshake and the interrupt state in reset
`timescale 1ns/1ps
`include "na_macros.svh"

module na_ct_sva (
  input logic                             clk_i,
  input logic                             arst_n_i,
  input na_pkg::flit_t [`NA_CHANNELS-1:0] noc_out_flit_i,
  input na_pkg::chan_t                    noc_out_valid_i,
  input na_pkg::chan_t                    noc_out_ready_i,
  input na_pkg::chan_t                    irq_i
);

  for (genvar c = 0; c < `NA_CHANNELS; c++) begin : g_chan
    // Stalled flit stays put
    a_flit_stable: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      noc_out_valid_i[c] && !noc_out_ready_i[c] |=> $stable(noc_out_flit_i[c])
    ) else $error("NoC output %0d changed a stalled flit", c);

    // Valid only drops after a transfer
    a_valid_hold: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      noc_out_valid_i[c] && !noc_out_ready_i[c] |=> noc_out_valid_i[c]
    ) else $error("NoC output %0d dropped valid without a transfer", c);
  end

  a_irq_reset: assert property (@(posedge clk_i) !arst_n_i |-> irq_i == '0)
    else $error("Interrupt raised during reset");

endmodule

bind na_ct na_ct_sva u_sva (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .noc_out_flit_i (noc_out_flit_o),
  .noc_out_valid_i(noc_out_valid_o),
  .noc_out_ready_i(noc_out_ready_i),
  .irq_i          (irq_o)
);

/* tb/tb_na_ct.sv */
// Testbench for the compute-tile network adapter
// Bus and NoC driver tasks, directed tests, watchdog and result report
`timescale 1ns/1ps
`include "na_macros.svh"

module tb_na_ct;

  localparam int NUM_TESTS = 5;
  localparam int MAX_WAIT  = 40;

  logic                             clk;
  logic                             arst_n;
  na_pkg::flit_t [`NA_CHANNELS-1:0] noc_in_flit;
  na_pkg::chan_t                    noc_in_valid;
  na_pkg::chan_t                    noc_in_ready;
  na_pkg::flit_t [`NA_CHANNELS-1:0] noc_out_flit;
  na_pkg::chan_t                    noc_out_valid;
  na_pkg::chan_t                    noc_out_ready;
  na_pkg::bus_req_t                 bus_req;
  na_pkg::word_t                    hwdata;
  na_pkg::bus_rsp_t                 bus_rsp;
  na_pkg::chan_t                    irq;

  na_pkg::flit_t out_q0 [$];
  na_pkg::flit_t out_q1 [$];
  integer        seed;
  int            errors;
  int            checks;

  na_ct UUT (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .noc_in_flit_i  (noc_in_flit),
    .noc_in_valid_i (noc_in_valid),
    .noc_in_ready_o (noc_in_ready),
    .noc_out_flit_o (noc_out_flit),
    .noc_out_valid_o(noc_out_valid),
    .noc_out_ready_i(noc_out_ready),
    .bus_req_i      (bus_req),
    .hwdata_i       (hwdata),
    .bus_rsp_o      (bus_rsp),
    .irq_o          (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * 2000);
    $display("Watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  // Outbound transfers, sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (noc_out_valid[0] && noc_out_ready[0])
        out_q0.push_back(noc_out_flit[0]);
      if (noc_out_valid[1] && noc_out_ready[1])
        out_q1.push_back(noc_out_flit[1]);
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check(input na_pkg::word_t actual, input na_pkg::word_t expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0d ns: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic report(input string name, input int start);
    if (errors == start)
      $display("%0d ns: %s ok", $time, name);
    else
      $display("%0d ns: %s had %0d errors", $time, name, errors - start);
  endtask

  // Region in bits 23..20, channel in bit 12
  function automatic na_pkg::addr_t mp_addr(input logic ch, input logic [3:0] ofs);
    return {`NA_REGION_MP, 7'd0, ch, 8'd0, ofs};
  endfunction

  function automatic na_pkg::flit_t make_flit(input logic last, input na_pkg::word_t data);
    na_pkg::flit_t f;
    f.last = last;
    f.data = data;
    return f;
  endfunction

  // Single NONSEQ transfer, entered and left 1 ns after a rising edge
  task automatic bus_xfer(input logic write, input na_pkg::addr_t addr,
                          input na_pkg::word_t wdata, output na_pkg::word_t rdata,
                          output int waits);
    bus_req.sel   = 1'b1;
    bus_req.write = write;
    bus_req.trans = `NA_HTRANS_NONSEQ;
    bus_req.addr  = addr;
    @(posedge clk);
    #1;
    bus_req = '0;
    hwdata  = wdata;
    waits   = 0;
    @(negedge clk);
    while (!bus_rsp.ready && waits < MAX_WAIT) begin
      waits++;
      @(negedge clk);
    end
    if (!bus_rsp.ready) begin
      errors++;
      $display("Bus transfer to %h never completed, hready stayed low", addr);
    end
    rdata = bus_rsp.rdata;
    @(posedge clk);
    #1;
    hwdata = '0;
  endtask

  task automatic bus_write(input na_pkg::addr_t addr, input na_pkg::word_t data,
                           output int waits);
    na_pkg::word_t unused;
    bus_xfer(1'b1, addr, data, unused, waits);
  endtask

  task automatic bus_read(input na_pkg::addr_t addr, output na_pkg::word_t data);
    int waits;
    bus_xfer(1'b0, addr, '0, data, waits);
  endtask

  // Hold the flit until the input buffer takes it
  task automatic noc_send(input logic ch, input na_pkg::flit_t flit);
    int cycles;
    cycles           = 0;
    noc_in_flit[ch]  = flit;
    noc_in_valid[ch] = 1'b1;
    @(negedge clk);
    while (!noc_in_ready[ch] && cycles < MAX_WAIT) begin
      cycles++;
      @(negedge clk);
    end
    if (!noc_in_ready[ch]) begin
      errors++;
      $display("NoC input %0d never accepted the offered flit", ch);
    end
    @(posedge clk);
    #1;
    noc_in_valid[ch] = 1'b0;
  endtask

  task automatic wait_flits(input logic ch, input int n);
    int cycles;
    cycles = 0;
    while (((ch ? out_q1.size() : out_q0.size()) < n) && cycles < MAX_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if ((ch ? out_q1.size() : out_q0.size()) < n) begin
      errors++;
      $display("NoC output %0d delivered too few flits", ch);
    end
  endtask

  task automatic wait_irq(input logic ch, input logic level);
    int cycles;
    cycles = 0;
    while (irq[ch] !== level && cycles < MAX_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (irq[ch] !== level) begin
      errors++;
      $display("Interrupt %0d never reached level %0b", ch, level);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic read_config_map();
    int            start;
    na_pkg::word_t rd;
    start = errors;
    bus_read(24'h000000, rd);
    check(rd, `NA_TILE_ID, "tile id");
    bus_read(24'h000004, rd);
    check(rd, `NA_CORE_BASE, "core base");
    bus_read(24'h000008, rd);
    check(rd, 32'd2, "channel count");
    bus_read(24'h200000, rd);
    check(rd, 32'd0, "unmapped region read");
    report("configuration map", start);
  endtask

  task automatic send_packet();
    int            start;
    int            base;
    int            base1;
    int            waits;
    na_pkg::word_t d [3];
    start = errors;
    base  = out_q0.size();
    base1 = out_q1.size();
    for (int i = 0; i < 3; i++)
      d[i] = $random(seed);
    bus_write(mp_addr(1'b0, `NA_OFS_DATA), d[0], waits);
    // Flit shows up one cycle after the data phase
    @(negedge clk);
    check(32'(noc_out_valid[0]), 0, "noc_out valid right after write");
    @(negedge clk);
    check(32'(noc_out_valid[0]), 1, "noc_out valid one cycle later");
    @(posedge clk);
    #1;
    bus_write(mp_addr(1'b0, `NA_OFS_DATA), d[1], waits);
    bus_write(mp_addr(1'b0, `NA_OFS_DATA_LAST), d[2], waits);
    wait_flits(1'b0, base + 3);
    for (int i = 0; i < 3; i++) begin
      check(out_q0[base + i].data, d[i], "sent flit data");
      check(32'(out_q0[base + i].last), 32'(i == 2), "sent flit last");
    end
    check(32'(out_q1.size()), 32'(base1), "channel 1 idle");
    report("send", start);
  endtask

  task automatic stall_on_full_output();
    int            start;
    int            base;
    int            waits;
    na_pkg::word_t d [5];
    start = errors;
    base  = out_q1.size();
    for (int i = 0; i < 5; i++)
      d[i] = $random(seed);
    noc_out_ready[1] = 1'b0;
    for (int i = 0; i < 4; i++) begin
      bus_write(mp_addr(1'b1, `NA_OFS_DATA), d[i], waits);
      check(32'(waits), 0, "write into free output buffer");
    end
    fork
      bus_write(mp_addr(1'b1, `NA_OFS_DATA), d[4], waits);
      begin
        @(posedge clk);
        repeat (3) begin
          @(negedge clk);
          check(32'(bus_rsp.ready), 0, "hready during stalled write");
        end
        @(posedge clk);
        #1;
        noc_out_ready[1] = 1'b1;
      end
    join
    check(32'(waits >= 3), 1, "stalled write wait states");
    wait_flits(1'b1, base + 5);
    for (int i = 0; i < 5; i++)
      check(out_q1[base + i].data, d[i], "flit order after stall");
    report("output back-pressure", start);
  endtask

  task automatic receive_with_irq();
    int            start;
    na_pkg::word_t rd;
    na_pkg::word_t d [2];
    start = errors;
    d[0]  = $random(seed);
    d[1]  = $random(seed);
    noc_send(1'b1, make_flit(1'b0, d[0]));
    noc_send(1'b1, make_flit(1'b1, d[1]));
    wait_irq(1'b1, 1'b1);
    check(32'(irq[0]), 0, "irq of idle channel");
    bus_read(mp_addr(1'b1, `NA_OFS_STATUS), rd);
    check(rd, 32'h1, "status with first flit at head");
    bus_read(mp_addr(1'b1, `NA_OFS_DATA), rd);
    check(rd, d[0], "first received flit");
    bus_read(mp_addr(1'b1, `NA_OFS_STATUS), rd);
    check(rd, 32'h3, "status with last flit at head");
    bus_read(mp_addr(1'b1, `NA_OFS_DATA), rd);
    check(rd, d[1], "second received flit");
    wait_irq(1'b1, 1'b0);
    bus_read(mp_addr(1'b1, `NA_OFS_DATA), rd);
    check(rd, 32'h0, "read of empty channel");
    report("receive and interrupt", start);
  endtask

  task automatic stall_on_full_input();
    int            start;
    na_pkg::word_t rd;
    na_pkg::word_t d [5];
    start = errors;
    for (int i = 0; i < 5; i++)
      d[i] = $random(seed);
    for (int i = 0; i < 4; i++)
      noc_send(1'b0, make_flit(1'b0, d[i]));
    fork
      noc_send(1'b0, make_flit(1'b0, d[4]));
      begin
        repeat (3) begin
          @(negedge clk);
          check(32'(noc_in_ready[0]), 0, "input ready with full buffer");
        end
        @(posedge clk);
        #1;
        bus_read(mp_addr(1'b0, `NA_OFS_DATA), rd);
        check(rd, d[0], "first flit after input stall");
      end
    join
    for (int i = 1; i < 5; i++) begin
      bus_read(mp_addr(1'b0, `NA_OFS_DATA), rd);
      check(rd, d[i], "flit order after input stall");
    end
    report("input back-pressure", start);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed          = 32'h4d15b2ab;
    errors        = 0;
    checks        = 0;
    arst_n        = 1'b0;
    noc_in_flit   = '0;
    noc_in_valid  = '0;
    noc_out_ready = '1;
    bus_req       = '0;
    hwdata        = '0;
    repeat (5) @(posedge clk);
    check(32'(noc_out_valid), 0, "noc_out valid in reset");
    check(32'(irq), 0, "irq in reset");
    check(32'(bus_rsp.ready), 1, "hready in reset");
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check(32'(noc_in_ready), 0, "input ready at reset release");
    @(posedge clk);
    #1;
    check(32'(noc_in_ready), 32'h3, "input ready one cycle after reset");
    read_config_map();
    send_packet();
    stall_on_full_output();
    receive_with_irq();
    stall_on_full_input();
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
